/* list.f */
ccu_pkg.sv
cfg_slot.sv
ccu_fsm.sv
isa_fetch.sv
isa_decoder.sv
ccu_top.sv
tb_clock.sv
tb_ccu_top.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_ccu_top \
    -f list.f --Mdir obj_dir -o tb_ccu_top

./obj_dir/tb_ccu_top > sim.log 2>&1 || true
cat sim.log

grep -q "STATUS: PASS" sim.log

/* tb_ccu_top.sv */
// Testbench for the configuration control unit
// GLB ISA memory model with random address back-pressure, and a step
// table of target ready levels and expected configuration records
`default_nettype none

module tb_ccu_top;
    timeunit 1ns;
    timeprecision 100ps;
    import ccu_pkg::*;

    localparam int TIMEOUT    = 300;   // Cycles per wait
    localparam int MEM_DEPTH  = 64;
    localparam int LAYOUT_LEN = 9;
    localparam int NUM_STEPS  = 4;
    localparam int LAYERS     = 2;
    localparam int EV_RST     = 0;
    localparam int EV_ADDR    = 1;
    localparam int EV_KNN_HS  = 2;
    localparam int EV_SYA_VLD = 3;
    localparam int EV_SYA_HS  = 4;
    localparam int EV_DONE    = 5;

    typedef struct packed {
        logic       knn_rdy;
        logic       sya_rdy;
        logic       is_sya;   // Target whose record is expected
        logic       rec;      // Index into that target's record table
        logic [3:0] hold;     // Cycles with ready low once valid is up
    } step_t;

    typedef struct packed {
        logic [OPCODE_W-1:0] op;
        logic                rec;
        logic                word;
    } isa_ent_t;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    logic                knn_cfg_rdy_i;
    logic                sya_cfg_rdy_i;
    logic                isa_addr_rdy_i = 1'b0;
    logic [WORD_W-1:0]   isa_dat_i = '0;
    logic                isa_dat_vld_i = 1'b0;
    logic                net_done_o;
    logic [ADDR_W-1:0]   isa_addr_o;
    logic                isa_addr_vld_o;
    logic                isa_dat_rdy_o;
    logic [ADDR_W-1:0]   isa_rd_addr_min_o;
    logic                knn_rst_o;
    logic                sya_rst_o;
    logic                knn_cfg_vld_o;
    logic                sya_cfg_vld_o;
    knn_cfg_t            knn_cfg_o;
    sya_cfg_t            sya_cfg_o;

    logic [WORD_W-1:0]   isa_mem [MEM_DEPTH];
    logic [ADDR_W-1:0]   exp_addr_q [$];    // Reads the DUT must issue, in order
    logic [ADDR_W-1:0]   exp_a;
    logic [ADDR_W-1:0]   rd_addr;
    logic                addr_rdy_nxt;      // Address ready seen at the coming edge
    logic                addr_taken = 1'b0;
    logic                dat_shown = 1'b0;
    logic                abort = 1'b0;
    int                  model_ptr [NUM_REQ];
    int                  mismatches = 0;
    int                  other_errs = 0;
    int                  done_pulses = 0;
    int                  seed = 32'h7830eaec;

    // ========================================
    // Tables
    // ========================================
    knn_cfg_t knn_tbl [2] = '{
        '{nip: 16'd1024, k: 6'd16, crd_rd_addr: 16'h0400, map_wr_addr: 16'h2C00},
        '{nip: 16'd512,  k: 6'd32, crd_rd_addr: 16'h0800, map_wr_addr: 16'h3000}
    };

    sya_cfg_t sya_tbl [2] = '{
        '{shift: 8'd7, zp: 8'h80, mode: 2'd1, ofm_phase_shift: 1'b1, chn: 12'd64,
          scale: 20'h3A5F1, act_rd_base: 16'h1000, wgt_rd_base: 16'h4000,
          ofm_wr_base: 16'h5800},
        '{shift: 8'd9, zp: 8'h7E, mode: 2'd2, ofm_phase_shift: 1'b0, chn: 12'd128,
          scale: 20'h0C3B2, act_rd_base: 16'h5800, wgt_rd_base: 16'h4400,
          ofm_wr_base: 16'h6000}
    };

    // Interleaved words, two with opcodes of dropped engines
    isa_ent_t layout [LAYOUT_LEN] = '{
        '{OP_KNN, 1'b0, 1'b0},
        '{OP_SYA, 1'b0, 1'b0},
        '{8'h03,  1'b0, 1'b0},
        '{OP_CCU, 1'b0, 1'b0},
        '{OP_SYA, 1'b0, 1'b1},
        '{OP_KNN, 1'b1, 1'b0},
        '{8'h05,  1'b0, 1'b0},
        '{OP_SYA, 1'b1, 1'b0},
        '{OP_SYA, 1'b1, 1'b1}
    };

    step_t steps [NUM_STEPS] = '{
        '{1'b1, 1'b1, 1'b0, 1'b0, 4'd0},   // All ready, KNN follows the control word
        '{1'b0, 1'b1, 1'b1, 1'b0, 4'd4},   // Back-pressure on the systolic array
        '{1'b1, 1'b0, 1'b0, 1'b1, 4'd0},
        '{1'b0, 1'b1, 1'b1, 1'b1, 4'd0}
    };

    tb_clock #(.PERIOD_NS(8), .RST_CYCLES(16)) u_clock (.clk(clk), .rst_n(rst_n));

    ccu_top #(.ADDR_W(ADDR_W)) uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .net_done_o        (net_done_o),
        .isa_addr_o        (isa_addr_o),
        .isa_addr_vld_o    (isa_addr_vld_o),
        .isa_addr_rdy_i    (isa_addr_rdy_i),
        .isa_dat_i         (isa_dat_i),
        .isa_dat_vld_i     (isa_dat_vld_i),
        .isa_dat_rdy_o     (isa_dat_rdy_o),
        .isa_rd_addr_min_o (isa_rd_addr_min_o),
        .knn_rst_o         (knn_rst_o),
        .knn_cfg_vld_o     (knn_cfg_vld_o),
        .knn_cfg_rdy_i     (knn_cfg_rdy_i),
        .knn_cfg_o         (knn_cfg_o),
        .sya_rst_o         (sya_rst_o),
        .sya_cfg_vld_o     (sya_cfg_vld_o),
        .sya_cfg_rdy_i     (sya_cfg_rdy_i),
        .sya_cfg_o         (sya_cfg_o)
    );

    task automatic show_mismatch(input string name, input logic [WORD_W-1:0] got,
                                 input logic [WORD_W-1:0] exp);
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        mismatches++;
    endtask

    // Fields go in record order from bit 8 upward
    function automatic logic [WORD_W-1:0] make_word(input isa_ent_t e, input int addr);
        logic [WORD_W-1:0] w;
        knn_cfg_t          k;
        sya_cfg_t          s;
        w = '0;
        k = knn_tbl[e.rec];
        s = sya_tbl[e.rec];
        if (e.op == OP_CCU)
            w[OPCODE_W +: 16] = 16'(LAYERS);
        else if (e.op == OP_KNN)
            w[OPCODE_W +: 54] = {k.map_wr_addr, k.crd_rd_addr, k.k, k.nip};
        else if (e.op == OP_SYA && !e.word)
            w[OPCODE_W +: 51] = {s.scale, s.chn, s.ofm_phase_shift, s.mode, s.zp, s.shift};
        else if (e.op == OP_SYA)
            w[OPCODE_W +: 48] = {s.ofm_wr_base, s.wgt_rd_base, s.act_rd_base};
        else
            w[WORD_W-1:OPCODE_W] = {15{8'(addr) ^ 8'h5A}};
        w[OPCODE_W-1:0] = e.op;
        return w;
    endfunction

    task automatic build_memory();
        for (int a = 0; a < MEM_DEPTH; a++)
            isa_mem[a] = {{7{16'(a) ^ 16'hC3A5}}, 8'h00, 8'hFF};   // Opcode 0xFF, foreign
        for (int a = 0; a < LAYOUT_LEN; a++)
            isa_mem[a] = make_word(layout[a], a);
        for (int r = 0; r < NUM_REQ; r++)
            model_ptr[r] = 0;
    endtask

    // Reads one record of a requester needs, skipped words included
    task automatic expect_reads(input int req);
        int a;
        for (int w = 0; w < ((req == 2) ? 2 : 1); w++) begin
            a = model_ptr[req];
            while (a < MEM_DEPTH - 1 && isa_mem[a][OPCODE_W-1:0] != OPCODE_W'(req)) begin
                exp_addr_q.push_back(ADDR_W'(a));
                a++;
            end
            exp_addr_q.push_back(ADDR_W'(a));
            model_ptr[req] = a + 1;
        end
    endtask

    function automatic logic [ADDR_W-1:0] model_min();
        int m;
        m = model_ptr[0];
        for (int r = 1; r < NUM_REQ; r++)
            if (model_ptr[r] < m)
                m = model_ptr[r];
        return ADDR_W'(m);
    endfunction

    function automatic logic event_seen(input int ev);
        case (ev)
            EV_RST:     return rst_n;
            EV_ADDR:    return isa_addr_vld_o;
            EV_KNN_HS:  return knn_cfg_vld_o && knn_cfg_rdy_i;
            EV_SYA_VLD: return sya_cfg_vld_o;
            EV_SYA_HS:  return sya_cfg_vld_o && sya_cfg_rdy_i;
            default:    return net_done_o;
        endcase
    endfunction

    task automatic wait_event(input int ev, input string what);
        int cnt;
        cnt = 0;
        while (!event_seen(ev) && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        assert (cnt < TIMEOUT) else begin
            $display("ERROR: timed out waiting for %s", what);
            other_errs++;
            abort = 1'b1;
        end
    endtask

    // ========================================
    // GLB ISA memory model
    // ========================================
    always @(negedge clk) begin
        if (!rst_n) begin
            isa_addr_rdy_i <= 1'b0;
            isa_dat_vld_i  <= 1'b0;
            addr_taken = 1'b0;
            dat_shown  = 1'b0;
        end else begin
            addr_rdy_nxt = ($random(seed) & 3) != 0;
            if (dat_shown) begin
                isa_dat_vld_i <= 1'b0;   // Taken at the last rising edge
                dat_shown = 1'b0;
            end
            if (addr_taken) begin
                assert (isa_dat_rdy_o) else begin
                    $display("ERROR: ISA data ready is low while a read is pending");
                    other_errs++;
                end
                isa_dat_i     <= isa_mem[int'(rd_addr) % MEM_DEPTH];
                isa_dat_vld_i <= 1'b1;
                dat_shown  = 1'b1;
                addr_taken = 1'b0;
            end
            if (isa_addr_vld_o && addr_rdy_nxt) begin
                assert (exp_addr_q.size() != 0) else begin
                    $display("ERROR: unexpected ISA read at address %h", isa_addr_o);
                    other_errs++;
                end
                if (exp_addr_q.size() != 0) begin
                    exp_a = exp_addr_q.pop_front();
                    assert (isa_addr_o == exp_a) else
                        show_mismatch("isa_addr_o", isa_addr_o, exp_a);
                end
                rd_addr    = isa_addr_o;
                addr_taken = 1'b1;
            end
            isa_addr_rdy_i <= addr_rdy_nxt;
        end
    end

    always @(negedge clk) begin
        if (net_done_o)
            done_pulses++;
    end

    // ========================================
    // Stimulus
    // ========================================
    task automatic run_step(input int s);
        step_t    st;
        knn_cfg_t exp_k;
        sya_cfg_t exp_s;
        st    = steps[s];
        exp_k = knn_tbl[st.rec];
        exp_s = sya_tbl[st.rec];
        expect_reads(st.is_sya ? 2 : 1);
        knn_cfg_rdy_i = st.knn_rdy;
        sya_cfg_rdy_i = st.sya_rdy;
        if (!st.is_sya) begin
            wait_event(EV_KNN_HS, "the KNN configuration handshake");
            if (abort)
                return;
            assert (knn_cfg_o == exp_k) else show_mismatch("knn_cfg_o", knn_cfg_o, exp_k);
            assert (!sya_cfg_vld_o) else show_mismatch("sya_cfg_vld_o", sya_cfg_vld_o, 0);
        end else begin
            if (st.hold != 0) begin
                wait_event(EV_ADDR, "the first ISA address");
                if (abort)
                    return;
                sya_cfg_rdy_i = 1'b0;   // Target busy once its fetch runs
                wait_event(EV_SYA_VLD, "the systolic-array valid");
                if (abort)
                    return;
                for (int h = 0; h < st.hold; h++) begin
                    assert (sya_cfg_vld_o) else begin
                        $display("ERROR: systolic-array valid dropped while ready was low");
                        other_errs++;
                    end
                    assert (sya_cfg_o == exp_s) else
                        show_mismatch("sya_cfg_o", sya_cfg_o, exp_s);
                    @(negedge clk);
                end
                sya_cfg_rdy_i = 1'b1;
            end
            wait_event(EV_SYA_HS, "the systolic-array configuration handshake");
            if (abort)
                return;
            assert (sya_cfg_o == exp_s) else show_mismatch("sya_cfg_o", sya_cfg_o, exp_s);
            assert (!knn_cfg_vld_o) else show_mismatch("knn_cfg_vld_o", knn_cfg_vld_o, 0);
        end
        assert (isa_rd_addr_min_o == model_min()) else
            show_mismatch("isa_rd_addr_min_o", isa_rd_addr_min_o, model_min());
        @(negedge clk);   // Let the handshake edge pass
    endtask

    initial begin
        start_i       = 1'b0;
        knn_cfg_rdy_i = 1'b0;
        sya_cfg_rdy_i = 1'b0;
        build_memory();
        @(negedge clk);
        wait_event(EV_RST, "reset release");
        assert (!knn_cfg_vld_o && !sya_cfg_vld_o && !net_done_o) else begin
            $display("ERROR: a valid or the network-finished pulse is high after reset");
            other_errs++;
        end
        assert (knn_rst_o && sya_rst_o) else begin
            $display("ERROR: engine resets are not high after reset");
            other_errs++;
        end
        expect_reads(0);
        start_i = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        assert (!knn_rst_o && !sya_rst_o) else begin
            $display("ERROR: engine resets stayed high after the start pulse");
            other_errs++;
        end
        for (int s = 0; s < NUM_STEPS; s++)
            if (!abort)
                run_step(s);
        knn_cfg_rdy_i = 1'b0;
        sya_cfg_rdy_i = 1'b0;
        if (!abort) begin
            wait_event(EV_DONE, "the network-finished pulse");
            @(negedge clk);
            assert (!net_done_o && done_pulses == 1) else begin
                $display("ERROR: network-finished was high for %0d cycles", done_pulses);
                other_errs++;
            end
            assert (knn_rst_o && sya_rst_o) else begin
                $display("ERROR: engine resets did not return high after the network");
                other_errs++;
            end
            assert (exp_addr_q.size() == 0) else begin
                $display("ERROR: %0d expected ISA reads were never issued", exp_addr_q.size());
                other_errs++;
            end
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
// Testbench clock and reset generator
// Free-running clock, reset held low for a number of cycles
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release between rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* ccu_top.sv */
// Configuration control unit of the point-cloud accelerator
// Sequencer, ISA fetch and decoder, with one configuration
// slot each for the KNN engine and the systolic array
`default_nettype none

module ccu_top #(
    parameter int ADDR_W = ccu_pkg::ADDR_W
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start_i,
    output logic                        net_done_o,
    // GLB ISA read
    output logic [ADDR_W-1:0]           isa_addr_o,
    output logic                        isa_addr_vld_o,
    input  wire                         isa_addr_rdy_i,
    input  wire [ccu_pkg::WORD_W-1:0]   isa_dat_i,
    input  wire                         isa_dat_vld_i,
    output logic                        isa_dat_rdy_o,
    output logic [ADDR_W-1:0]           isa_rd_addr_min_o,
    // KNN engine
    output logic                        knn_rst_o,
    output logic                        knn_cfg_vld_o,
    input  wire                         knn_cfg_rdy_i,
    output ccu_pkg::knn_cfg_t           knn_cfg_o,
    // Systolic array
    output logic                        sya_rst_o,
    output logic                        sya_cfg_vld_o,
    input  wire                         sya_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t           sya_cfg_o
);
    import ccu_pkg::*;

    ccu_state_e           state;
    logic [REQ_IDX_W-1:0] sel;
    logic [IDX_W-1:0]     num_layers;
    logic                 ccu_load;
    logic                 knn_load;
    logic                 sya_load;
    isa_rd_t              rd;
    knn_cfg_t             knn_dec;
    sya_cfg_t             sya_dec;

    // ========================================
    // Sequencer
    // ========================================
    ccu_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .num_layers_i (num_layers),
        .ccu_load_i   (ccu_load),
        .knn_rdy_i    (knn_cfg_rdy_i),
        .sya_rdy_i    (sya_cfg_rdy_i),
        .knn_vld_i    (knn_cfg_vld_o),
        .sya_vld_i    (sya_cfg_vld_o),
        .state_o      (state),
        .sel_o        (sel),
        .net_done_o   (net_done_o),
        .knn_rst_o    (knn_rst_o),
        .sya_rst_o    (sya_rst_o)
    );

    // ========================================
    // ISA fetch and decode
    // ========================================
    isa_fetch #(
        .ADDR_W (ADDR_W)
    ) u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .state_i        (state),
        .sel_i          (sel),
        .isa_addr_rdy_i (isa_addr_rdy_i),
        .isa_dat_i      (isa_dat_i),
        .isa_dat_vld_i  (isa_dat_vld_i),
        .isa_addr_o     (isa_addr_o),
        .isa_addr_vld_o (isa_addr_vld_o),
        .isa_dat_rdy_o  (isa_dat_rdy_o),
        .rd_o           (rd),
        .rd_addr_min_o  (isa_rd_addr_min_o)
    );

    isa_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_i         (rd),
        .dat_i        (isa_dat_i),
        .num_layers_o (num_layers),
        .ccu_load_o   (ccu_load),
        .knn_o        (knn_dec),
        .knn_load_o   (knn_load),
        .sya_o        (sya_dec),
        .sya_load_o   (sya_load)
    );

    // ========================================
    // Configuration slots
    // ========================================
    cfg_slot #(
        .payload_t (knn_cfg_t)
    ) u_knn_slot (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (knn_load),
        .data_i (knn_dec),
        .rdy_i  (knn_cfg_rdy_i),
        .vld_o  (knn_cfg_vld_o),
        .data_o (knn_cfg_o)
    );

    cfg_slot #(
        .payload_t (sya_cfg_t)
    ) u_sya_slot (
        .clk    (clk),
        .rst_n  (rst_n),
        .load_i (sya_load),
        .data_i (sya_dec),
        .rdy_i  (sya_cfg_rdy_i),
        .vld_o  (sya_cfg_vld_o),
        .data_o (sya_cfg_o)
    );

endmodule

`default_nettype wire

/* isa_decoder.sv */
// ISA decoder
// Slices matched ISA words into the control, KNN and systolic-array
// records and pulses a load with the last word of each record
`default_nettype none

module isa_decoder (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire ccu_pkg::isa_rd_t       rd_i,
    input  wire [ccu_pkg::WORD_W-1:0]   dat_i,
    output logic [ccu_pkg::IDX_W-1:0]   num_layers_o,
    output logic                        ccu_load_o,
    output ccu_pkg::knn_cfg_t           knn_o,
    output logic                        knn_load_o,
    output ccu_pkg::sya_cfg_t           sya_o,
    output logic                        sya_load_o
);
    import ccu_pkg::*;

    // Field positions, fields packed upward from the opcode
    localparam int KNN_K    = OPCODE_W + IDX_W;
    localparam int KNN_CRD  = KNN_K + K_W;
    localparam int KNN_MAP  = KNN_CRD + ADDR_W;
    localparam int S0_MODE  = 2 * ACT_W;          // Offsets inside held word 0
    localparam int S0_PHS   = S0_MODE + MODE_W;
    localparam int S0_CHN   = S0_PHS + 1;
    localparam int S0_SCALE = S0_CHN + CHN_W;
    localparam int SYA_W0_W = S0_SCALE + SCALE_W;

    logic [OPCODE_W-1:0] req_op;
    logic                is_ccu;
    logic                is_knn;
    logic                is_sya;
    logic [SYA_W0_W-1:0] sya_w0_q;      // SYA word 0 fields
    logic                sya_w0_seen_q;

    assign req_op = OPCODE_W'(rd_i.req);
    assign is_ccu = rd_i.vld && req_op == OP_CCU;
    assign is_knn = rd_i.vld && req_op == OP_KNN;
    assign is_sya = rd_i.vld && req_op == OP_SYA;

    // ========================================
    // Systolic-array word 0 holding
    // ========================================
    always_ff @(posedge clk) begin
        if (is_sya && !rd_i.word)
            sya_w0_q <= dat_i[OPCODE_W +: SYA_W0_W];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sya_w0_seen_q <= 1'b0;
        else if (is_sya)
            sya_w0_seen_q <= !rd_i.word;   // Set by word 0, cleared by word 1
    end

    // ========================================
    // Records and load pulses
    // ========================================
    assign num_layers_o = dat_i[OPCODE_W +: IDX_W];
    assign ccu_load_o   = is_ccu && rd_i.last;
    assign knn_load_o   = is_knn && rd_i.last;
    assign sya_load_o   = is_sya && rd_i.last && sya_w0_seen_q;

    always_comb begin
        knn_o.nip         = dat_i[OPCODE_W +: IDX_W];
        knn_o.k           = dat_i[KNN_K +: K_W];
        knn_o.crd_rd_addr = dat_i[KNN_CRD +: ADDR_W];
        knn_o.map_wr_addr = dat_i[KNN_MAP +: ADDR_W];
    end

    always_comb begin
        sya_o.shift           = sya_w0_q[0 +: ACT_W];
        sya_o.zp              = sya_w0_q[ACT_W +: ACT_W];
        sya_o.mode            = sya_w0_q[S0_MODE +: MODE_W];
        sya_o.ofm_phase_shift = sya_w0_q[S0_PHS];
        sya_o.chn             = sya_w0_q[S0_CHN +: CHN_W];
        sya_o.scale           = sya_w0_q[S0_SCALE +: SCALE_W];
        sya_o.act_rd_base     = dat_i[OPCODE_W +: ADDR_W];   // Word 1 is live
        sya_o.wgt_rd_base     = dat_i[OPCODE_W + ADDR_W +: ADDR_W];
        sya_o.ofm_wr_base     = dat_i[OPCODE_W + 2 * ADDR_W +: ADDR_W];
    end

endmodule

`default_nettype wire

/* isa_fetch.sv */
// ISA fetch
// Reads the selected requester's words from the GLB ISA memory with
// one read outstanding, skips foreign opcodes and keeps one read
// pointer per requester plus the smallest of them
`default_nettype none

module isa_fetch #(
    parameter int ADDR_W = ccu_pkg::ADDR_W
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire ccu_pkg::ccu_state_e      state_i,
    input  wire [ccu_pkg::REQ_IDX_W-1:0]  sel_i,
    input  wire                           isa_addr_rdy_i,
    input  wire [ccu_pkg::WORD_W-1:0]     isa_dat_i,
    input  wire                           isa_dat_vld_i,
    output logic [ADDR_W-1:0]             isa_addr_o,
    output logic                          isa_addr_vld_o,
    output logic                          isa_dat_rdy_o,
    output ccu_pkg::isa_rd_t              rd_o,
    output logic [ADDR_W-1:0]             rd_addr_min_o
);
    import ccu_pkg::*;

    logic [ADDR_W-1:0] ptr_q [NUM_REQ];
    logic              pend_q;      // Read issued, data not yet taken
    logic              done_q;      // Last matching word taken
    logic              wcnt_q;      // Matching words so far
    logic              in_cfg;
    logic              addr_hs;
    logic              dat_hs;
    logic              op_match;
    logic              last_word;

    assign in_cfg    = state_i == CFG;
    assign addr_hs   = isa_addr_vld_o && isa_addr_rdy_i;
    assign dat_hs    = isa_dat_vld_i && pend_q;
    assign op_match  = isa_dat_i[OPCODE_W-1:0] == OPCODE_W'(sel_i);
    assign last_word = {1'b0, wcnt_q} == req_words(sel_i) - 2'd1;

    // ========================================
    // GLB address and data channels
    // ========================================
    assign isa_addr_o     = ptr_q[sel_i];
    assign isa_addr_vld_o = in_cfg && !pend_q && !done_q;
    assign isa_dat_rdy_o  = pend_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pend_q <= 1'b0;
        else if (addr_hs)
            pend_q <= 1'b1;
        else if (dat_hs)
            pend_q <= 1'b0;
    end

    // Skipped words move the pointer as well
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REQ; i++)
                ptr_q[i] <= '0;
        end else begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (state_i == IDLE)
                    ptr_q[i] <= '0;
                else if (addr_hs && sel_i == REQ_IDX_W'(i))
                    ptr_q[i] <= ptr_q[i] + 1'b1;
            end
        end
    end

    // ========================================
    // Word counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wcnt_q <= 1'b0;
            done_q <= 1'b0;
        end else if (!in_cfg) begin
            wcnt_q <= 1'b0;
            done_q <= 1'b0;
        end else if (dat_hs && op_match) begin
            wcnt_q <= !last_word;   // Records are at most two words
            done_q <= last_word;
        end
    end

    always_comb begin
        rd_o.vld  = dat_hs && op_match;
        rd_o.req  = sel_i;
        rd_o.word = wcnt_q;
        rd_o.last = last_word;
    end

    // Loader may overwrite words below this address
    always_comb begin
        rd_addr_min_o = ptr_q[0];
        for (int i = 1; i < NUM_REQ; i++) begin
            if (ptr_q[i] < rd_addr_min_o)
                rd_addr_min_o = ptr_q[i];
        end
    end

endmodule

`default_nettype wire

/* ccu_fsm.sv */
// Configuration sequencer
// Picks the ready requester by fixed priority, waits for its
// configuration to complete and counts systolic-array layers
// until the network is finished
`default_nettype none

module ccu_fsm (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           start_i,
    input  wire [ccu_pkg::IDX_W-1:0]      num_layers_i,
    input  wire                           ccu_load_i,
    input  wire                           knn_rdy_i,
    input  wire                           sya_rdy_i,
    input  wire                           knn_vld_i,
    input  wire                           sya_vld_i,
    output ccu_pkg::ccu_state_e           state_o,
    output logic [ccu_pkg::REQ_IDX_W-1:0] sel_o,
    output logic                          net_done_o,
    output logic                          knn_rst_o,
    output logic                          sya_rst_o
);
    import ccu_pkg::*;

    ccu_state_e           state_q;
    ccu_state_e           state_d;
    logic                 ccu_rdy_q;     // Own ready flag
    logic [NUM_REQ-1:0]   req_rdy;
    logic [NUM_REQ-1:0]   cfg_hs;
    logic [REQ_IDX_W-1:0] pick;
    logic [REQ_IDX_W-1:0] sel_q;
    logic [IDX_W-1:0]     num_layers_q;
    logic [IDX_W-1:0]     layer_cnt_q;
    logic                 sya_hs;
    logic                 net_fin;

    assign req_rdy = {sya_rdy_i, knn_rdy_i, ccu_rdy_q};
    assign sya_hs  = sya_vld_i && sya_rdy_i;
    assign cfg_hs  = {sya_hs, knn_vld_i && knn_rdy_i, ccu_load_i};
    assign net_fin = (num_layers_q != '0) && (layer_cnt_q == num_layers_q);

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req_rdy[i])
                pick = REQ_IDX_W'(i);
        end
    end

    // ========================================
    // State machine
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_i)
                    state_d = IDLE_CFG;
            IDLE_CFG:
                if (net_fin)
                    state_d = NET_DONE;
                else if (|req_rdy)
                    state_d = CFG;
            CFG:
                if (cfg_hs[sel_q])   // Selected target took its record
                    state_d = IDLE_CFG;
            default:
                state_d = IDLE;      // NET_DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            sel_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE_CFG && state_d == CFG)
                sel_q <= pick;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ccu_rdy_q <= 1'b1;
        else if (state_q == IDLE)
            ccu_rdy_q <= 1'b1;
        else if (ccu_load_i)
            ccu_rdy_q <= 1'b0;
    end

    // ========================================
    // Layer count
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            num_layers_q <= '0;
            layer_cnt_q  <= '0;
        end else if (state_q == IDLE) begin
            num_layers_q <= '0;
            layer_cnt_q  <= '0;
        end else begin
            if (ccu_load_i)
                num_layers_q <= num_layers_i;
            if (sya_hs)
                layer_cnt_q <= layer_cnt_q + 1'b1;   // One layer per SYA config
        end
    end

    assign state_o    = state_q;
    assign sel_o      = sel_q;
    assign net_done_o = state_q == NET_DONE;
    assign knn_rst_o  = state_q == IDLE;
    assign sya_rst_o  = state_q == IDLE;

endmodule

`default_nettype wire

/* cfg_slot.sv */
// Configuration slot
// Captures one record on load and offers it to the target
// with a valid level that is held until the target is ready
`default_nettype none

module cfg_slot #(
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           load_i,
    input  wire payload_t data_i,
    input  wire           rdy_i,
    output logic          vld_o,
    output payload_t      data_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            vld_o <= 1'b0;
        else if (load_i)
            vld_o <= 1'b1;
        else if (rdy_i)
            vld_o <= 1'b0;   // Handshake, or nothing held
    end

    // Record stays stable while valid is up
    always_ff @(posedge clk) begin
        if (load_i)
            data_o <= data_i;
    end

endmodule

`default_nettype wire

/* ccu_pkg.sv */
// Configuration control unit shared definitions
// Widths, opcodes, FSM states and the configuration records
// carried between the ISA fetch, decoder and configuration slots
`default_nettype none

package ccu_pkg;

    // ========================================
    // Widths and counts
    // ========================================
    localparam int WORD_W    = 128;  // ISA word from the GLB
    localparam int OPCODE_W  = 8;    // Low bits of every word
    localparam int ADDR_W    = 16;
    localparam int IDX_W     = 16;   // Point index, also layer number
    localparam int NUM_REQ   = 3;
    localparam int REQ_IDX_W = 2;

    // Record field widths
    localparam int K_W     = 6;
    localparam int ACT_W   = 8;
    localparam int MODE_W  = 2;
    localparam int CHN_W   = 12;
    localparam int SCALE_W = 20;

    // ========================================
    // Opcodes, equal to the requester index
    // ========================================
    localparam logic [OPCODE_W-1:0] OP_CCU = 8'd0;
    localparam logic [OPCODE_W-1:0] OP_KNN = 8'd1;
    localparam logic [OPCODE_W-1:0] OP_SYA = 8'd2;

    // Number of ISA words in one record of a requester
    function automatic logic [1:0] req_words(input logic [REQ_IDX_W-1:0] idx);
        if (OPCODE_W'(idx) == OP_SYA) begin
            return 2'd2;
        end
        return 2'd1;
    endfunction

    // ========================================
    // Types
    // ========================================
    typedef enum logic [1:0] {
        IDLE,
        IDLE_CFG,
        CFG,
        NET_DONE
    } ccu_state_e;

    typedef struct packed {
        logic [IDX_W-1:0]  nip;          // Input point count
        logic [K_W-1:0]    k;
        logic [ADDR_W-1:0] crd_rd_addr;  // Coordinate read address
        logic [ADDR_W-1:0] map_wr_addr;
    } knn_cfg_t;

    typedef struct packed {
        // Word 0
        logic [ACT_W-1:0]   shift;
        logic [ACT_W-1:0]   zp;
        logic [MODE_W-1:0]  mode;
        logic               ofm_phase_shift;
        logic [CHN_W-1:0]   chn;
        logic [SCALE_W-1:0] scale;
        // Word 1
        logic [ADDR_W-1:0]  act_rd_base;
        logic [ADDR_W-1:0]  wgt_rd_base;
        logic [ADDR_W-1:0]  ofm_wr_base;
    } sya_cfg_t;

    // Strobe for one matched ISA word
    typedef struct packed {
        logic                 vld;
        logic [REQ_IDX_W-1:0] req;
        logic                 word;   // Word number within the record
        logic                 last;
    } isa_rd_t;

endpackage

`default_nettype wire
